//--- bench/tb_cpu_periphs.sv
// Directed-test testbench for the CPU peripheral block with AXI-lite bus tasks and a watchdog
module tb_cpu_periphs import periph_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 5;
	localparam int STALL_N      = 23;
	localparam int TMR_K        = 10;
	localparam int WDOG_K       = 16;
	localparam int REARMS       = 6;

	// Run length estimate from bus transfers and the idle waits of the tests
	localparam int BUS_OPS      = 40;
	localparam int OP_CYCLES    = 8;
	localparam int WAIT_CYCLES  = RESET_CYCLES + STALL_N + TMR_K + 8 + 4 * WDOG_K + 24;
	localparam int LIMIT_CYCLES = 2 * (BUS_OPS * OP_CYCLES + WAIT_CYCLES);

	logic        S_AXI_ACLK = 1'b0;
	logic        i_cpu_reset;
	logic        awvalid, awready, wvalid, wready, bvalid, bready;
	logic        arvalid, arready, rvalid, rready;
	logic [5:0]  awaddr, araddr;
	logic [31:0] wdata, rdata;
	logic [3:0]  wstrb;
	logic [1:0]  bresp, rresp;
	logic        halted, opstall, pfstall, icount, ext_int;
	logic        interrupt, watchdog_reset;

	int unsigned cycle_count = 0;
	int unsigned accept_cycle;
	int unsigned wdog_pulses = 0;
	int unsigned last_pulse_cycle = 0;
	logic [31:0] rng_state = 32'hc717_6d12;

	cpu_periphs #(.C_AXI_ADDR_WIDTH(6)) uut (
		.S_AXI_ACLK, .i_cpu_reset,
		.S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready), .S_AXI_AWADDR(awaddr),
		.S_AXI_WVALID(wvalid), .S_AXI_WREADY(wready), .S_AXI_WDATA(wdata),
		.S_AXI_WSTRB(wstrb), .S_AXI_BVALID(bvalid), .S_AXI_BREADY(bready),
		.S_AXI_BRESP(bresp), .S_AXI_ARVALID(arvalid), .S_AXI_ARREADY(arready),
		.S_AXI_ARADDR(araddr), .S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready),
		.S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp),
		.i_cpu_halted(halted), .i_cpu_opstall(opstall), .i_cpu_pfstall(pfstall),
		.i_cpu_icount(icount), .i_ext_int(ext_int),
		.o_interrupt(interrupt), .o_watchdog_reset(watchdog_reset)
	);

	initial begin
		forever #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// Cycle stamp and watchdog pulse monitor
	always @(posedge S_AXI_ACLK) begin
		cycle_count <= cycle_count + 1;
		if (watchdog_reset) begin
			wdog_pulses      <= wdog_pulses + 1;
			last_pulse_cycle <= cycle_count;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_with_failure();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERROR: time %0d ns: %s: got 0x%08h, expected 0x%08h",
				$time, what, got, expected);
			stop_with_failure();
		end
	endtask

	task automatic axil_write(input int slot, input logic [31:0] data, input logic [3:0] strb);
		@(posedge S_AXI_ACLK);
		awvalid <= 1'b1;
		awaddr  <= 6'(slot * 4);
		wvalid  <= 1'b1;
		wdata   <= data;
		wstrb   <= strb;
		bready  <= 1'b1;
		do @(posedge S_AXI_ACLK); while (!awready);
		accept_cycle = cycle_count;
		check_value("WREADY with AWREADY", 32'(wready), 32'd1);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do @(posedge S_AXI_ACLK); while (!bvalid);
		check_value("BRESP", 32'(bresp), 32'd0);
		bready <= 1'b0;
	endtask

	task automatic axil_read(input int slot, output logic [31:0] data);
		@(posedge S_AXI_ACLK);
		arvalid <= 1'b1;
		araddr  <= 6'(slot * 4);
		rready  <= 1'b1;
		do @(posedge S_AXI_ACLK); while (!arready);
		arvalid <= 1'b0;
		do @(posedge S_AXI_ACLK); while (!rvalid);
		data = rdata;
		check_value("RRESP", 32'(rresp), 32'd0);
		rready <= 1'b0;
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic reset_state();
		int slots [8] = '{SLOT_PIC, SLOT_WDOG, 3, SLOT_TMRA, SLOT_MCLOCKS, SLOT_MOPSTALL,
			SLOT_MPFSTALL, SLOT_MICOUNT};
		logic [31:0] v;
		foreach (slots[i]) begin
			axil_read(slots[i], v);
			check_value($sformatf("slot %0d after reset", slots[i]), v, 32'h0);
		end
		check_value("interrupt after reset", 32'(interrupt), 32'd0);
		check_value("watchdog reset after reset", 32'(watchdog_reset), 32'd0);
	endtask

	task automatic counter_merge_and_count();
		logic [31:0] v;
		logic [31:0] expected;
		rng_state = next_random(rng_state);
		// Bytes 0 and 2 land on a zero counter
		expected = rng_state & 32'h00ff_00ff;
		axil_write(SLOT_MOPSTALL, rng_state, 4'b0101);
		axil_read(SLOT_MOPSTALL, v);
		check_value("opstall strobe merge", v, expected);
		@(posedge S_AXI_ACLK);
		opstall <= 1'b1;
		repeat (STALL_N) @(posedge S_AXI_ACLK);
		opstall <= 1'b0;
		axil_read(SLOT_MOPSTALL, v);
		check_value("opstall after events", v, expected + STALL_N);
	endtask

	task automatic timer_a_oneshot();
		logic [31:0] v;
		axil_write(SLOT_TMRA, 32'(TMR_K), 4'hf);
		axil_read(SLOT_TMRA, v);
		check_value("timer A load", v, 32'(TMR_K));
		axil_read(SLOT_TMRA, v);
		check_value("timer A frozen while halted", v, 32'(TMR_K));
		@(posedge S_AXI_ACLK);
		halted <= 1'b0;
		repeat (TMR_K + 6) @(posedge S_AXI_ACLK);
		axil_read(SLOT_TMRA, v);
		check_value("timer A expired", v, 32'h0);
		// Pending at position 1 with nothing enabled
		axil_read(SLOT_PIC, v);
		check_value("PIC after timer A", v, 32'h0000_0002);
	endtask

	task automatic pic_enable_and_clear();
		logic [31:0] v;
		@(posedge S_AXI_ACLK);
		ext_int <= 1'b1;
		@(posedge S_AXI_ACLK);
		ext_int <= 1'b0;
		axil_read(SLOT_PIC, v);
		check_value("PIC pending external", v, 32'h0000_0003);
		check_value("interrupt with no enable", 32'(interrupt), 32'd0);
		axil_write(SLOT_PIC, 32'h8001_0000, 4'hf);
		check_value("interrupt after enable", 32'(interrupt), 32'd1);
		axil_read(SLOT_PIC, v);
		check_value("PIC enabled view", v, 32'h8001_0003);
		axil_write(SLOT_PIC, 32'h0000_0001, 4'hf);
		check_value("interrupt after clear", 32'(interrupt), 32'd0);
		axil_read(SLOT_PIC, v);
		check_value("PIC after clear", v, 32'h0001_0002);
	endtask

	task automatic watchdog_pulse_and_rearm();
		int unsigned base;
		int unsigned delay;
		base = wdog_pulses;
		axil_write(SLOT_WDOG, 32'(WDOG_K), 4'hf);
		while (wdog_pulses == base)
			@(posedge S_AXI_ACLK);
		delay = last_pulse_cycle - accept_cycle;
		check_value("watchdog delay within bound", 32'(delay <= WDOG_K + 4), 32'd1);
		repeat (2 * WDOG_K) @(posedge S_AXI_ACLK);
		check_value("watchdog pulse count", wdog_pulses, base + 1);
		// Rearming before expiry keeps it quiet
		base = wdog_pulses;
		for (int i = 0; i < REARMS; i++) begin
			axil_write(SLOT_WDOG, 32'(WDOG_K), 4'hf);
			repeat (2) @(posedge S_AXI_ACLK);
		end
		axil_write(SLOT_WDOG, 32'h0, 4'hf);
		repeat (WDOG_K + 8) @(posedge S_AXI_ACLK);
		check_value("watchdog pulses while rearmed", wdog_pulses, base);
	endtask

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
		stop_with_failure();
	end

	initial begin
		i_cpu_reset <= 1'b1;
		awvalid <= 1'b0;
		awaddr  <= '0;
		wvalid  <= 1'b0;
		wdata   <= '0;
		wstrb   <= '0;
		bready  <= 1'b0;
		arvalid <= 1'b0;
		araddr  <= '0;
		rready  <= 1'b0;
		halted  <= 1'b1;
		opstall <= 1'b0;
		pfstall <= 1'b0;
		icount  <= 1'b0;
		ext_int <= 1'b0;
		repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
		i_cpu_reset <= 1'b0;
		reset_state();
		counter_merge_and_count();
		timer_a_oneshot();
		pic_enable_and_clear();
		watchdog_pulse_and_rearm();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- hw/axil_regif.sv
// AXI-lite slave with write slot decode and registered read mux
module axil_regif import periph_pkg::*; #(
	parameter int C_AXI_ADDR_WIDTH = 6
) (
	input  logic                        S_AXI_ACLK,
	input  logic                        i_cpu_reset,
	input  logic                        S_AXI_AWVALID,
	output logic                        S_AXI_AWREADY,
	input  logic [C_AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR,
	input  logic                        S_AXI_WVALID,
	output logic                        S_AXI_WREADY,
	input  logic [DATA_WIDTH-1:0]       S_AXI_WDATA,
	input  logic [STRB_WIDTH-1:0]       S_AXI_WSTRB,
	output logic                        S_AXI_BVALID,
	input  logic                        S_AXI_BREADY,
	output logic [1:0]                  S_AXI_BRESP,
	input  logic                        S_AXI_ARVALID,
	output logic                        S_AXI_ARREADY,
	input  logic [C_AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR,
	output logic                        S_AXI_RVALID,
	input  logic                        S_AXI_RREADY,
	output logic [DATA_WIDTH-1:0]       S_AXI_RDATA,
	output logic [1:0]                  S_AXI_RRESP,
	regbus_if.regs                      bus
);
	// Byte offset bits below the word index
	localparam int ADDRLSB = $clog2(DATA_WIDTH) - 3;

	logic                  axil_awready;
	logic                  axil_bvalid;
	logic                  axil_rvalid;
	logic [DATA_WIDTH-1:0] axil_rdata;
	logic [SLOT_BITS-1:0]  aw_slot;
	logic [SLOT_BITS-1:0]  ar_slot;
	logic                  read_accept;

	assign aw_slot = S_AXI_AWADDR[ADDRLSB +: SLOT_BITS];
	assign ar_slot = S_AXI_ARADDR[ADDRLSB +: SLOT_BITS];

	//////////////////////////////
	// Write channel
	//////////////////////////////

	// Address and data accepted together and never while a response is stuck
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			axil_awready <= 1'b0;
		else
			axil_awready <= !axil_awready && S_AXI_AWVALID && S_AXI_WVALID
				&& (!axil_bvalid || S_AXI_BREADY);
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			axil_bvalid <= 1'b0;
		else if (axil_awready)
			axil_bvalid <= 1'b1;
		else if (S_AXI_BREADY)
			axil_bvalid <= 1'b0;
	end

	// Slot strobe in the acceptance cycle
	always_comb begin
		bus.wr_sel = '0;
		if (axil_awready)
			bus.wr_sel[aw_slot] = 1'b1;
	end

	assign bus.wr_data = S_AXI_WDATA;
	assign bus.wr_strb = S_AXI_WSTRB;

	assign S_AXI_AWREADY = axil_awready;
	assign S_AXI_WREADY  = axil_awready;
	assign S_AXI_BVALID  = axil_bvalid;
	assign S_AXI_BRESP   = 2'b00;

	//////////////////////////////
	// Read channel
	//////////////////////////////
	assign S_AXI_ARREADY = !axil_rvalid;
	assign read_accept   = S_AXI_ARVALID && !axil_rvalid;

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			axil_rvalid <= 1'b0;
		else if (read_accept)
			axil_rvalid <= 1'b1;
		else if (S_AXI_RREADY)
			axil_rvalid <= 1'b0;
	end

	// Captured once per read and held until RREADY
	always_ff @(posedge S_AXI_ACLK) begin
		if (read_accept)
			axil_rdata <= bus.rd_word[ar_slot];
	end

	assign S_AXI_RVALID = axil_rvalid;
	assign S_AXI_RDATA  = axil_rdata;
	assign S_AXI_RRESP  = 2'b00;

	// Responses held until taken
	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (i_cpu_reset)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);

	a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (i_cpu_reset)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID);

endmodule

//--- hw/cpu_periphs.sv
// Top level tying the AXI-lite slave to the PIC, watchdog, timer A and counters
module cpu_periphs import periph_pkg::*; #(
	parameter int C_AXI_ADDR_WIDTH = 6
) (
	input  logic                        S_AXI_ACLK,
	input  logic                        i_cpu_reset,
	input  logic                        S_AXI_AWVALID,
	output logic                        S_AXI_AWREADY,
	input  logic [C_AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR,
	input  logic                        S_AXI_WVALID,
	output logic                        S_AXI_WREADY,
	input  logic [DATA_WIDTH-1:0]       S_AXI_WDATA,
	input  logic [STRB_WIDTH-1:0]       S_AXI_WSTRB,
	output logic                        S_AXI_BVALID,
	input  logic                        S_AXI_BREADY,
	output logic [1:0]                  S_AXI_BRESP,
	input  logic                        S_AXI_ARVALID,
	output logic                        S_AXI_ARREADY,
	input  logic [C_AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR,
	output logic                        S_AXI_RVALID,
	input  logic                        S_AXI_RREADY,
	output logic [DATA_WIDTH-1:0]       S_AXI_RDATA,
	output logic [1:0]                  S_AXI_RRESP,
	input  logic                        i_cpu_halted,
	input  logic                        i_cpu_opstall,
	input  logic                        i_cpu_pfstall,
	input  logic                        i_cpu_icount,
	input  logic                        i_ext_int,
	output logic                        o_interrupt,
	output logic                        o_watchdog_reset
);
	// Slots that some peripheral answers
	localparam slot_mask_t USED_SLOTS = slot_mask_t'((1 << SLOT_PIC) | (1 << SLOT_WDOG)
		| (1 << SLOT_TMRA) | (1 << SLOT_MCLOCKS) | (1 << SLOT_MOPSTALL)
		| (1 << SLOT_MPFSTALL) | (1 << SLOT_MICOUNT));

	logic              cpu_ce;
	logic              tmra_int;
	logic [N_INTS-1:0] int_src;

	regbus_if bus ();

	// Timers stop while the CPU is halted
	assign cpu_ce = !i_cpu_halted;

	always_comb begin
		int_src           = '0;
		int_src[INT_EXT]  = i_ext_int;
		int_src[INT_TMRA] = tmra_int;
	end

	// Unmapped slots read zero
	for (genvar s = 0; s < N_SLOTS; s++) begin : g_tie
		if (!USED_SLOTS[s]) begin : g_zero
			assign bus.rd_word[s] = '0;
		end
	end

	axil_regif #(.C_AXI_ADDR_WIDTH(C_AXI_ADDR_WIDTH)) u_regif (
		.S_AXI_ACLK, .i_cpu_reset,
		.S_AXI_AWVALID, .S_AXI_AWREADY, .S_AXI_AWADDR,
		.S_AXI_WVALID, .S_AXI_WREADY, .S_AXI_WDATA, .S_AXI_WSTRB,
		.S_AXI_BVALID, .S_AXI_BREADY, .S_AXI_BRESP,
		.S_AXI_ARVALID, .S_AXI_ARREADY, .S_AXI_ARADDR,
		.S_AXI_RVALID, .S_AXI_RREADY, .S_AXI_RDATA, .S_AXI_RRESP,
		.bus(bus.regs)
	);

	int_controller u_pic (
		.S_AXI_ACLK, .i_cpu_reset,
		.i_sources(int_src), .bus(bus.periph), .o_interrupt
	);

	cpu_timer #(.SLOT(SLOT_WDOG), .OPT_RELOAD(1'b0)) u_watchdog (
		.S_AXI_ACLK, .i_cpu_reset,
		.i_ce(cpu_ce), .bus(bus.periph), .o_int(o_watchdog_reset)
	);

	cpu_timer #(.SLOT(SLOT_TMRA), .OPT_RELOAD(1'b1)) u_timer_a (
		.S_AXI_ACLK, .i_cpu_reset,
		.i_ce(cpu_ce), .bus(bus.periph), .o_int(tmra_int)
	);

	perf_counters u_counters (
		.S_AXI_ACLK, .i_cpu_reset,
		.i_cpu_halted, .i_cpu_opstall, .i_cpu_pfstall, .i_cpu_icount,
		.bus(bus.periph)
	);

endmodule

//--- hw/cpu_timer.sv
// Count-down timer with optional auto-reload and a single-cycle expiry pulse
module cpu_timer import periph_pkg::*; #(
	parameter int SLOT       = SLOT_TMRA,
	parameter bit OPT_RELOAD = 1'b1
) (
	input  logic     S_AXI_ACLK,
	input  logic     i_cpu_reset,
	input  logic     i_ce,
	regbus_if.periph bus,
	output logic     o_int
);
	// Count field below the reload flag
	localparam int CW = DATA_WIDTH - 1;

	logic [CW-1:0] count;
	logic [CW-1:0] interval;
	logic          auto_reload;
	logic          wr_tmr;
	logic          expire;

	assign wr_tmr = bus.wr_sel[SLOT];
	assign expire = i_ce && (count == CW'(1));

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset) begin
			count       <= '0;
			interval    <= '0;
			auto_reload <= 1'b0;
			o_int       <= 1'b0;
		end else if (wr_tmr) begin
			// A write restarts the count and cancels a due pulse
			count    <= bus.wr_data[CW-1:0];
			interval <= bus.wr_data[CW-1:0];
			// One-cycle intervals run one-shot
			auto_reload <= OPT_RELOAD && bus.wr_data[CW]
				&& (bus.wr_data[CW-1:1] != '0);
			o_int <= 1'b0;
		end else begin
			o_int <= expire;
			if (expire)
				count <= auto_reload ? interval : '0;
			else if (i_ce && (count != '0))
				count <= count - 1'b1;
		end
	end

	assign bus.rd_word[SLOT] = {auto_reload, count};

	a_int_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (i_cpu_reset)
		o_int |=> !o_int);

endmodule

//--- hw/int_controller.sv
// Interrupt controller with pending and enable bits and a combined interrupt output
module int_controller import periph_pkg::*; (
	input  logic              S_AXI_ACLK,
	input  logic              i_cpu_reset,
	input  logic [N_INTS-1:0] i_sources,
	regbus_if.periph          bus,
	output logic              o_interrupt
);
	logic [N_INTS-1:0] pending;
	logic [N_INTS-1:0] enable;
	logic              wr_pic;
	pic_word_u         wr_word;
	pic_rd_t           rd_view;

	assign wr_pic  = bus.wr_sel[SLOT_PIC];
	assign wr_word = bus.wr_data;

	// Sources latch high; a live source beats a clear
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			pending <= '0;
		else if (wr_pic)
			pending <= (pending & ~wr_word.wr.clr_bits) | i_sources;
		else
			pending <= pending | i_sources;
	end

	// Bit 31 picks set or clear for the chosen enables
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			enable <= '0;
		else if (wr_pic) begin
			if (wr_word.wr.en_set)
				enable <= enable | wr_word.wr.en_bits;
			else
				enable <= enable & ~wr_word.wr.en_bits;
		end
	end

	assign o_interrupt = |(pending & enable);

	always_comb begin
		rd_view.irq     = o_interrupt;
		rd_view.enables = enable;
		rd_view.zero    = 1'b0;
		rd_view.pending = pending;
	end

	assign bus.rd_word[SLOT_PIC] = rd_view;

	// An enabled pending bit stays until software writes the PIC
	a_irq_hold: assert property (@(posedge S_AXI_ACLK) disable iff (i_cpu_reset)
		o_interrupt && !wr_pic |=> o_interrupt);

endmodule

//--- hw/perf_counters.sv
// Supervisor performance counters with byte-strobe writes
module perf_counters import periph_pkg::*; (
	input  logic     S_AXI_ACLK,
	input  logic     i_cpu_reset,
	input  logic     i_cpu_halted,
	input  logic     i_cpu_opstall,
	input  logic     i_cpu_pfstall,
	input  logic     i_cpu_icount,
	regbus_if.periph bus
);
	localparam int N_CNT = 4;
	localparam int CNT_SLOT [N_CNT] = '{SLOT_MCLOCKS, SLOT_MOPSTALL,
		SLOT_MPFSTALL, SLOT_MICOUNT};

	logic [DATA_WIDTH-1:0] counter [N_CNT];
	logic [N_CNT-1:0]      event_v;

	// Replace only the strobed bytes
	function automatic logic [DATA_WIDTH-1:0] apply_strb(
		input logic [DATA_WIDTH-1:0] prior,
		input logic [DATA_WIDTH-1:0] new_data,
		input logic [STRB_WIDTH-1:0] strb
	);
		logic [DATA_WIDTH-1:0] merged;
		merged = prior;
		for (int b = 0; b < STRB_WIDTH; b++) begin
			if (strb[b])
				merged[8*b +: 8] = new_data[8*b +: 8];
		end
		return merged;
	endfunction

	// Same order as CNT_SLOT
	assign event_v = {i_cpu_icount, i_cpu_pfstall, i_cpu_opstall, !i_cpu_halted};

	always_ff @(posedge S_AXI_ACLK) begin
		for (int k = 0; k < N_CNT; k++) begin
			if (i_cpu_reset)
				counter[k] <= '0;
			else if (bus.wr_sel[CNT_SLOT[k]])
				// Unwritten bytes still see this cycle's event
				counter[k] <= apply_strb(counter[k] + DATA_WIDTH'(event_v[k]),
					bus.wr_data, bus.wr_strb);
			else if (event_v[k])
				counter[k] <= counter[k] + 1'b1;
		end
	end

	for (genvar g = 0; g < N_CNT; g++) begin : g_rd
		assign bus.rd_word[CNT_SLOT[g]] = counter[g];
	end

endmodule

//--- hw/periph_pkg.sv
// Shared widths, register slot map, interrupt positions and interrupt-controller word types
package periph_pkg;

	//////////////////////////////
	// Bus widths
	//////////////////////////////
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	localparam int SLOT_BITS  = 4;
	localparam int N_SLOTS    = 1 << SLOT_BITS;

	//////////////////////////////
	// Word slots
	//////////////////////////////
	localparam int SLOT_PIC      = 0;
	localparam int SLOT_WDOG     = 1;
	localparam int SLOT_TMRA     = 4;
	localparam int SLOT_MCLOCKS  = 8;
	localparam int SLOT_MOPSTALL = 9;
	localparam int SLOT_MPFSTALL = 10;
	localparam int SLOT_MICOUNT  = 11;

	// Interrupt source positions
	localparam int N_INTS   = 15;
	localparam int INT_EXT  = 0;
	localparam int INT_TMRA = 1;

	typedef logic [N_SLOTS-1:0] slot_mask_t;

	// PIC word as read back
	typedef struct packed {
		logic              irq;
		logic [N_INTS-1:0] enables;
		logic              zero;
		logic [N_INTS-1:0] pending;
	} pic_rd_t;

	// PIC word as written
	typedef struct packed {
		logic              en_set;
		logic [N_INTS-1:0] en_bits;
		logic              unused;
		logic [N_INTS-1:0] clr_bits;
	} pic_wr_t;

	typedef union packed {
		pic_rd_t rd;
		pic_wr_t wr;
	} pic_word_u;

endpackage

//--- hw/regbus_if.sv
// Register bus interface between the AXI-lite slave and the peripherals
interface regbus_if;

	// One-hot write strobe, valid for a single cycle
	periph_pkg::slot_mask_t             wr_sel;
	logic [periph_pkg::DATA_WIDTH-1:0] wr_data;
	logic [periph_pkg::STRB_WIDTH-1:0] wr_strb;

	// Live read value of every word slot
	logic [periph_pkg::DATA_WIDTH-1:0] rd_word [periph_pkg::N_SLOTS];

	modport regs (
		output wr_sel,
		output wr_data,
		output wr_strb,
		input  rd_word
	);

	modport periph (
		input  wr_sel,
		input  wr_data,
		input  wr_strb,
		output rd_word
	);

endinterface

//--- project.f
hw/periph_pkg.sv
hw/regbus_if.sv
hw/axil_regif.sv
hw/int_controller.sv
hw/cpu_timer.sv
hw/perf_counters.sv
hw/cpu_periphs.sv
bench/tb_cpu_periphs.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and judge the result from the simulation log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_cpu_periphs -f project.f -o tb_cpu_periphs > build.log 2>&1 &&
./obj_dir/tb_cpu_periphs > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "^TESTS PASSED$" sim.log && echo "Result: pass" ||
{ echo "Result: fail"; exit 1; }
